//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int MEM_WORDS  = 256;
  localparam int MEM_ADDR_W = $clog2(MEM_WORDS); // word index into memory

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // major opcodes
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
    ALU_PASS_B // lui
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JUMP
  } br_t;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // stores and branches share this layout
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm; // lui/auipc upper bits or scrambled jal offset
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } instr_u;

endpackage

`default_nettype wire

//--- inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  cpu_pkg::instr_u                 instr,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  rs1,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  rs2,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  rd,
  output logic [cpu_pkg::XLEN-1:0]        imm,
  output cpu_pkg::alu_op_t                alu_op,
  output cpu_pkg::br_t                    br_kind,
  output cpu_pkg::wb_sel_t                wb_sel,
  output logic                            alu_src_imm,
  output logic                            alu_src_pc,
  output logic                            reg_we,
  output logic                            mem_we,
  output logic                            mem_byte,
  output logic                            jalr
);
  import cpu_pkg::*;

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0]      funct3;
  logic            alt;     // funct7[5] picks sub/sra
  logic            r_ok;
  logic            imm_ok;

  function automatic alu_op_t alu_fn(input logic [2:0] f3, input logic sub_sra);
    alu_op_t op;
    case (f3)
      3'b000:  op = sub_sra ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = sub_sra ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign funct3 = instr.r.funct3;
  assign alt    = instr.r.funct7[5];

  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{20{instr.s.imm_hi[6]}}, instr.s.imm_lo[0], instr.s.imm_hi[5:0],
                  instr.s.imm_lo[4:1], 1'b0};
  assign imm_u = {instr.u.imm, 12'b0};
  assign imm_j = {{12{instr.u.imm[19]}}, instr.u.imm[7:0], instr.u.imm[8],
                  instr.u.imm[18:9], 1'b0};

  // only add/sub and srl/sra have an alternate funct7
  assign r_ok = (instr.r.funct7 == 7'b0) ||
                (instr.r.funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    case (funct3)
      3'b001:  imm_ok = instr.r.funct7 == 7'b0;
      3'b101:  imm_ok = instr.r.funct7 == 7'b0 || instr.r.funct7 == 7'b0100000;
      default: imm_ok = 1'b1;
    endcase
  end

  always_comb begin
    // unknown encodings fall out as no-ops
    rs1         = '0;
    rs2         = '0;
    rd          = '0;
    imm         = '0;
    alu_op      = ALU_ADD;
    br_kind     = BR_NONE;
    wb_sel      = WB_ALU;
    alu_src_imm = 1'b0;
    alu_src_pc  = 1'b0;
    reg_we      = 1'b0;
    mem_we      = 1'b0;
    mem_byte    = 1'b0;
    jalr        = 1'b0;
    case (instr.r.opcode)
      OP_REG: begin
        rs1    = instr.r.rs1;
        rs2    = instr.r.rs2;
        rd     = instr.r.rd;
        alu_op = alu_fn(funct3, alt);
        reg_we = r_ok;
      end
      OP_IMM: begin
        rs1         = instr.i.rs1;
        rd          = instr.i.rd;
        imm         = imm_i;
        alu_src_imm = 1'b1;
        alu_op      = alu_fn(funct3, funct3 == 3'b101 && alt); // srai only
        reg_we      = imm_ok;
      end
      OP_LOAD: begin
        rs1         = instr.i.rs1;
        rd          = instr.i.rd;
        imm         = imm_i;
        alu_src_imm = 1'b1;
        wb_sel      = WB_MEM;
        mem_byte    = funct3 == 3'b100;                      // lbu
        reg_we      = funct3 == 3'b010 || funct3 == 3'b100;
      end
      OP_STORE: begin
        rs1         = instr.s.rs1;
        rs2         = instr.s.rs2;
        imm         = imm_s;
        alu_src_imm = 1'b1;
        mem_byte    = funct3 == 3'b000;                      // sb
        mem_we      = funct3 == 3'b000 || funct3 == 3'b010;
      end
      OP_BRANCH: begin
        rs1 = instr.s.rs1;
        rs2 = instr.s.rs2;
        imm = imm_b;
        case (funct3)
          3'b000:  br_kind = BR_BEQ;
          3'b001:  br_kind = BR_BNE;
          3'b100:  br_kind = BR_BLT;
          3'b101:  br_kind = BR_BGE;
          3'b110:  br_kind = BR_BLTU;
          3'b111:  br_kind = BR_BGEU;
          default: br_kind = BR_NONE;
        endcase
      end
      OP_LUI, OP_AUIPC: begin
        rd          = instr.u.rd;
        imm         = imm_u;
        alu_src_imm = 1'b1;
        alu_src_pc  = instr.u.opcode == OP_AUIPC;
        alu_op      = (instr.u.opcode == OP_AUIPC) ? ALU_ADD : ALU_PASS_B;
        reg_we      = 1'b1;
      end
      OP_JAL: begin
        rd      = instr.u.rd;
        imm     = imm_j;
        br_kind = BR_JUMP;
        wb_sel  = WB_LINK;
        reg_we  = 1'b1;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          rs1     = instr.i.rs1;
          rd      = instr.i.rd;
          imm     = imm_i;
          br_kind = BR_JUMP;
          jalr    = 1'b1;
          wb_sel  = WB_LINK;
          reg_we  = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [cpu_pkg::XLEN-1:0] a,
  input  logic [cpu_pkg::XLEN-1:0] b,
  input  logic [cpu_pkg::XLEN-1:0] imm,
  input  logic [cpu_pkg::XLEN-1:0] pc,
  input  cpu_pkg::alu_op_t         alu_op,
  input  logic                     alu_src_imm,
  input  logic                     alu_src_pc,
  output logic [cpu_pkg::XLEN-1:0] result,
  output logic                     eq,
  output logic                     lt,
  output logic                     ltu
);
  import cpu_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;

  assign op_a  = alu_src_pc ? pc : a;   // auipc
  assign op_b  = alu_src_imm ? imm : b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $signed(op_a) >>> shamt;
      ALU_AND:    result = op_a & op_b;
      ALU_OR:     result = op_a | op_b;
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  // branch flags always compare the two registers
  assign eq  = a == b;
  assign lt  = $signed(a) < $signed(b);
  assign ltu = a < b;

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            we,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  rs1,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  rs2,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  rd,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  dbg_addr,
  input  logic [cpu_pkg::XLEN-1:0]        wdata,
  output logic [cpu_pkg::XLEN-1:0]        rs1_data,
  output logic [cpu_pkg::XLEN-1:0]        rs2_data,
  output logic [cpu_pkg::XLEN-1:0]        dbg_data
);
  import cpu_pkg::*;

  logic [(1<<REG_ADDR_W)-1:0][XLEN-1:0] regs;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      regs <= '0;
    end else if (we && rd != '0) begin // x0 stays hardwired
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];
  assign dbg_data = regs[dbg_addr];

  a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
    else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

//--- pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     run,
  input  cpu_pkg::br_t             br_kind,
  input  logic                     jalr,
  input  logic                     eq,
  input  logic                     lt,
  input  logic                     ltu,
  input  logic [cpu_pkg::XLEN-1:0] imm,
  input  logic [cpu_pkg::XLEN-1:0] rs1_data,
  output logic [cpu_pkg::XLEN-1:0] pc,
  output logic [cpu_pkg::XLEN-1:0] link
);
  import cpu_pkg::*;

  logic            taken;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] jalr_target;

  always_comb begin
    case (br_kind)
      BR_BEQ:  taken = eq;
      BR_BNE:  taken = !eq;
      BR_BLT:  taken = lt;
      BR_BGE:  taken = !lt;
      BR_BLTU: taken = ltu;
      BR_BGEU: taken = !ltu;
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign link        = pc + 32'd4;
  assign jalr_target = (rs1_data + imm) & ~32'd1;
  assign next_pc     = jalr ? jalr_target : (taken ? pc + imm : link);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (run) begin
      pc <= next_pc;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

//--- memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory (
  input  logic                            clk,
  input  logic                            we,
  input  logic                            byte_en,
  input  logic                            load_en,
  input  logic [cpu_pkg::XLEN-1:0]        iaddr,
  input  logic [cpu_pkg::XLEN-1:0]        daddr,
  input  logic [cpu_pkg::XLEN-1:0]        wdata,
  input  logic [cpu_pkg::XLEN-1:0]        load_data,
  input  logic [cpu_pkg::MEM_ADDR_W-1:0]  load_addr,
  output cpu_pkg::instr_u                 instr,
  output logic [cpu_pkg::XLEN-1:0]        rdata
);
  import cpu_pkg::*;

  logic [XLEN-1:0]       mem [MEM_WORDS];
  logic [MEM_ADDR_W-1:0] iword;
  logic [MEM_ADDR_W-1:0] dword;
  logic [1:0]            lane;

  assign iword = iaddr[MEM_ADDR_W+1:2];
  assign dword = daddr[MEM_ADDR_W+1:2];
  assign lane  = daddr[1:0];

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data; // testbench load wins over a store
    end else if (we) begin
      if (byte_en) begin
        mem[dword][{lane, 3'b000} +: 8] <= wdata[7:0];
      end else begin
        mem[dword] <= wdata;
      end
    end
  end

  // both read ports are asynchronous
  assign instr = mem[iword];
  assign rdata = mem[dword];

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            run,
  input  logic                            load_en,
  input  logic [cpu_pkg::MEM_ADDR_W-1:0]  load_addr,
  input  logic [cpu_pkg::XLEN-1:0]        load_data,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  dbg_addr,
  output logic [cpu_pkg::XLEN-1:0]        dbg_data,
  output logic [cpu_pkg::XLEN-1:0]        pc
);
  import cpu_pkg::*;

  instr_u                instr;
  logic [REG_ADDR_W-1:0] rs1, rs2, rd;
  logic [XLEN-1:0]       imm, rs1_data, rs2_data, result, link;
  logic [XLEN-1:0]       mem_rdata, load_word, wb_data;
  logic [7:0]            load_byte;
  alu_op_t               alu_op;
  br_t                   br_kind;
  wb_sel_t               wb_sel;
  logic                  alu_src_imm, alu_src_pc, reg_we, mem_we, mem_byte, jalr;
  logic                  eq, lt, ltu;
  logic                  rf_we, dmem_we;

  // nothing commits unless the core runs
  assign rf_we   = reg_we & run;
  assign dmem_we = mem_we & run;

  assign load_byte = mem_rdata[{result[1:0], 3'b000} +: 8]; // lbu lane
  assign load_word = mem_byte ? {{(XLEN-8){1'b0}}, load_byte} : mem_rdata;

  always_comb begin
    case (wb_sel)
      WB_MEM:  wb_data = load_word;
      WB_LINK: wb_data = link;
      default: wb_data = result;
    endcase
  end

  inst_decoder inst_decoder_inst (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .br_kind(br_kind), .wb_sel(wb_sel),
    .alu_src_imm(alu_src_imm), .alu_src_pc(alu_src_pc), .reg_we(reg_we),
    .mem_we(mem_we), .mem_byte(mem_byte), .jalr(jalr)
  );

  register_file register_file_inst (
    .clk(clk), .rst(rst), .we(rf_we), .rs1(rs1), .rs2(rs2), .rd(rd),
    .dbg_addr(dbg_addr), .wdata(wb_data), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .dbg_data(dbg_data)
  );

  alu alu_inst (
    .a(rs1_data), .b(rs2_data), .imm(imm), .pc(pc), .alu_op(alu_op),
    .alu_src_imm(alu_src_imm), .alu_src_pc(alu_src_pc), .result(result),
    .eq(eq), .lt(lt), .ltu(ltu)
  );

  pc_unit pc_unit_inst (
    .clk(clk), .rst(rst), .run(run), .br_kind(br_kind), .jalr(jalr),
    .eq(eq), .lt(lt), .ltu(ltu), .imm(imm), .rs1_data(rs1_data),
    .pc(pc), .link(link)
  );

  memory memory_inst (
    .clk(clk), .we(dmem_we), .byte_en(mem_byte), .load_en(load_en),
    .iaddr(pc), .daddr(result), .wdata(rs2_data), .load_data(load_data),
    .load_addr(load_addr), .instr(instr), .rdata(mem_rdata)
  );

  // halted core keeps pc, register reads and data word frozen
  a_halt_holds: assert property (@(posedge clk) disable iff (rst)
    !run && !load_en |=> $stable({pc, rs1_data, rs2_data, mem_rdata}))
    else $error("state changed while run was low");

endmodule

`default_nettype wire

//--- cpu_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top_tb;
  import cpu_pkg::*;

  localparam int CLK_HALF     = 4;
  localparam int RESET_CYCLES = 4;

  logic                  clk;
  logic                  rst;
  logic                  run;
  logic                  load_en;
  logic [MEM_ADDR_W-1:0] load_addr;
  logic [XLEN-1:0]       load_data;
  logic [REG_ADDR_W-1:0] dbg_addr;
  logic [XLEN-1:0]       dbg_data;
  logic [XLEN-1:0]       pc;

  int checks;
  int errors;
  int test_errors;
  int tests;

  cpu_top cpu_top_inst (
    .clk(clk), .rst(rst), .run(run), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .dbg_addr(dbg_addr), .dbg_data(dbg_data), .pc(pc)
  );

  always #CLK_HALF clk = ~clk;

  task automatic check(input string sig, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", sig, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst     = 1'b1;
    run     = 1'b0;
    load_en = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  endtask

  // every word becomes addi x0,x0,addr so stray fetches do nothing
  task automatic fill_memory();
    int i;
    for (i = 0; i < MEM_WORDS; i++) begin
      @(posedge clk);
      #1;
      if (i == RESET_CYCLES) rst = 1'b0; // reset released during the fill
      load_en   = 1'b1;
      load_addr = i[MEM_ADDR_W-1:0];
      load_data = {4'h0, i[7:0], 20'h00013};
    end
    @(posedge clk);
    #1 load_en = 1'b0;
  endtask

  task automatic load_word(input logic [MEM_ADDR_W-1:0] addr, input logic [XLEN-1:0] word);
    @(posedge clk);
    #1;
    load_en   = 1'b1;
    load_addr = addr;
    load_data = word;
    @(posedge clk);
    #1 load_en = 1'b0;
  endtask

  task automatic read_reg(input logic [REG_ADDR_W-1:0] r, output logic [XLEN-1:0] val);
    @(posedge clk);
    #1 dbg_addr = r;
    @(negedge clk);
    val = dbg_data;
  endtask

  task automatic check_reset_state();
    logic [XLEN-1:0] val;
    int              r;
    @(negedge clk);
    check("pc", pc, RESET_PC);
    for (r = 0; r < (1 << REG_ADDR_W); r++) begin
      read_reg(r[REG_ADDR_W-1:0], val);
      check($sformatf("x%0d", r), val, 32'h0);
    end
  endtask

  // program ends in a self-jump, so pc parks at halt_pc
  task automatic run_until(input logic [XLEN-1:0] halt_pc, input int limit);
    int   n;
    logic reached;
    n       = 0;
    reached = 1'b0;
    @(posedge clk);
    #1 run = 1'b1;
    while (!reached && n < limit) begin
      @(posedge clk);
      #1;
      n++;
      if (pc == halt_pc) reached = 1'b1;
    end
    run = 1'b0;
    if (!reached) begin
      $display("timeout: pc is %h and never reached %h within %0d cycles", pc, halt_pc, limit);
      errors++;
      test_errors++;
    end
  endtask

  initial begin
    int               fd;
    int               code;
    int               r;
    int               cycles;
    logic [7:0]       tag;
    logic [8*16-1:0]  name;
    logic [8*128-1:0] line;
    logic [XLEN-1:0]  addr;
    logic [XLEN-1:0]  value;
    logic [XLEN-1:0]  got;
    logic             done;
    clk         = 1'b0;
    rst         = 1'b1;
    run         = 1'b0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    dbg_addr    = '0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    tests       = 0;
    name        = '0;
    fill_memory();

    fd = $fopen("cpu_top_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open stimulus file cpu_top_stim.txt");
      errors++;
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, "%s", tag);
        if (code != 1) begin
          done = 1'b1;                    // end of file
        end else if (tag == "#") begin
          code = $fgets(line, fd);
        end else if (tag == "T") begin
          code = $fscanf(fd, "%s", name);
          tests++;
          test_errors = 0;
          apply_reset();
          check_reset_state();
        end else if (tag == "L") begin
          code = $fscanf(fd, "%h %h", addr, value);
          load_word(addr[MEM_ADDR_W-1:0], value);
        end else if (tag == "R") begin
          code = $fscanf(fd, "%h %d", addr, cycles);
          run_until(addr, cycles);
        end else if (tag == "E") begin
          code = $fscanf(fd, "%d %h", r, value);
          read_reg(r[REG_ADDR_W-1:0], got);
          check($sformatf("x%0d", r), got, value);
        end else if (tag == "P") begin
          code = $fscanf(fd, "%h", value);
          @(negedge clk);
          check("pc", pc, value);
        end else if (tag == "D") begin
          if (test_errors == 0) begin
            $display("test %0s: ok", name);
          end else begin
            $display("test %0s: %0d errors", name, test_errors);
          end
        end else begin
          $display("unknown record %s in stimulus file", tag);
          errors++;
          done = 1'b1;
        end
      end
      $fclose(fd);
    end

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && tests > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cpu_top_stim.txt
# T name | L word_addr(hex) word(hex) | R halt_pc(hex) max_cycles(dec)
# E reg(dec) value(hex) | P pc(hex) | D ends the test
# register and immediate alu ops, x0 write ignored
T alu
L 00 FF800093
L 01 00300113
L 02 002081B3
L 03 40110233
L 04 4020D2B3
L 05 0020D333
L 06 0020A3B3
L 07 0020B433
L 08 0020C4B3
L 09 0020F533
L 0A 002115B3
L 0B FF90A613
L 0C FFF13693
L 0D 4010D713
L 0E 7F016793
L 0F 00500013
L 10 0000006F
R 40 100
E 0 00000000
E 3 FFFFFFFB
E 4 0000000B
E 5 FFFFFFFF
E 6 1FFFFFFF
E 7 00000001
E 8 00000000
E 9 FFFFFFFB
E 10 00000000
E 11 00000018
E 12 00000001
E 13 00000001
E 14 FFFFFFFC
E 15 000007F3
P 40
D
# sw/lw, sb into lane 2, lbu zero extension
T mem
L 00 10000093
L 01 0000A103
L 02 0AB00193
L 03 00308123
L 04 0000A203
L 05 0020A223
L 06 0040A283
L 07 0020C303
L 08 0030C383
L 09 0000006F
L 40 11223344
R 24 100
E 1 00000100
E 2 11223344
E 3 000000AB
E 4 11AB3344
E 5 11223344
E 6 000000AB
E 7 00000011
P 24
D
# each branch skips a marker addi when taken
T branch
L 00 FFF00093
L 01 00100113
L 02 00208463
L 03 00100193
L 04 00209463
L 05 00100213
L 06 0020C463
L 07 00100293
L 08 0020D463
L 09 00100313
L 0A 0020E463
L 0B 00100393
L 0C 0020F463
L 0D 00100413
L 0E 00108463
L 0F 00100493
L 10 00116463
L 11 00100513
L 12 00114463
L 13 00100593
L 14 0000006F
R 50 100
E 3 00000001
E 4 00000000
E 5 00000000
E 6 00000001
E 7 00000001
E 8 00000000
E 9 00000000
E 10 00000000
E 11 00000001
P 50
D
# jal, lui, auipc, jalr with odd target
T jump
L 00 00C000EF
L 01 00100293
L 02 00100293
L 03 12345137
L 04 00001197
L 05 01D08267
L 06 00100293
L 07 00100293
L 08 00700313
L 09 0000006F
R 24 100
E 1 00000004
E 2 12345000
E 3 00001010
E 4 00000018
E 5 00000000
E 6 00000007
P 24
D
# run low, loads must not disturb pc or registers
T hold
L 00 05500093
L 01 0000006F
R 04 20
E 1 00000055
P 04
L 00 00100093
L 01 00000013
L 02 00000013
E 1 00000055
P 04
D

//--- cpu_top.f
cpu_pkg.sv
inst_decoder.sv
alu.sv
register_file.sv
pc_unit.sv
memory.sv
cpu_top.sv
cpu_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the cpu_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cpu_top.f --top-module cpu_top_tb -o cpu_top_sim
./obj_dir/cpu_top_sim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "run_sim: passed"
  exit 0
fi
echo "run_sim: failed"
exit 1
